// ==== asg_buffer.sv ====
// waveform table, 2**CWM signed samples of DW bits
// bus word index sits at address bits CWM+1:2
// reads on either port return data one cycle later

`timescale 1ns/1ps

module asg_buffer import asg_pkg::*; #(
  parameter int unsigned CWM = 10,
  parameter int unsigned DW  = 14
) (
  input  logic           bus,
  input  logic           arst_n,
  input  logic           wen,
  input  logic           ren,
  input  bus_addr_t      addr,
  input  bus_data_t      wdata,
  output bus_data_t      rdata,
  output logic           ack,
  input  logic [CWM-1:0] rd_addr,
  input  logic           rd_vld,
  output logic [DW-1:0]  rd_dat,
  output logic           dat_vld
);

  logic [DW-1:0]  mem [2**CWM];
  logic [CWM-1:0] idx;
  logic           tbl_wr;
  logic           tbl_rd;

  assign idx    = addr[CWM+1:2];
  assign tbl_wr = wen & addr[TBL_BIT];
  assign tbl_rd = ren & addr[TBL_BIT];

  // bus port, write and sign extended read
  always_ff @(posedge bus) begin
    if (tbl_wr) begin
      mem[idx] <= wdata[DW-1:0];
    end
    if (tbl_rd) begin
      rdata <= {{(BUS_DW-DW){mem[idx][DW-1]}}, mem[idx]};
    end
  end

  // generator port
  always_ff @(posedge bus) begin
    rd_dat <= mem[rd_addr];
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ack     <= 1'b0;
      dat_vld <= 1'b0;
    end else begin
      ack     <= tbl_wr | tbl_rd;
      // valid follows the read pointer by one cycle
      dat_vld <= rd_vld;
    end
  end

endmodule

// ==== asg_core.sv ====
// read pointer and burst FSM of the generator
// trg_ext is taken as synchronous to bus, no synchronizer inside
// cfg_stp is expected below cfg_siz, one wrap per step at most
// burst data length or count of zero behaves as one

`timescale 1ns/1ps

module asg_core import asg_pkg::*; #(
  parameter int unsigned CWM = 10,
  parameter int unsigned CWF = 16,
  parameter int unsigned TN  = 4
) (
  input  logic               bus,
  input  logic               arst_n,
  input  logic [TN-1:0]      trg_ext,
  input  logic               trg_swo,
  input  logic               ctl_rst,
  input  logic [TN-1:0]      cfg_trg,
  input  logic [CWM+CWF-1:0] cfg_siz,
  input  logic [CWM+CWF-1:0] cfg_off,
  input  logic [CWM+CWF-1:0] cfg_stp,
  input  logic               cfg_ben,
  input  logic               cfg_inf,
  input  logic [CWM-1:0]     cfg_bdl,
  input  bil_t               cfg_bil,
  input  bnm_t               cfg_bnm,
  output logic [CWM-1:0]     rd_addr,
  output logic               rd_vld,
  output logic               trg_out
);

  localparam int unsigned PW = CWM + CWF;

  core_state_t     state;
  logic [PW-1:0]   ptr;
  logic [PW:0]     ptr_sum;
  logic [PW-1:0]   ptr_nxt;
  logic            wrap;
  logic [CWM-1:0]  dcnt;
  logic [CWM-1:0]  dcnt_nxt;
  bil_t            icnt;
  bil_t            icnt_nxt;
  bnm_t            ncnt;
  bnm_t            ncnt_nxt;
  logic            data_end;
  logic            burst_last;
  logic [TN-1:0]   trg_q;
  logic            start;

  //////////////////////////////////////////////////////////////////////
  // trigger detection
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      trg_q <= '0;
    end else begin
      trg_q <= trg_ext;
    end
  end

  // rising edge on any enabled input, or software
  assign start = trg_swo | (|(trg_ext & ~trg_q & cfg_trg));

  //////////////////////////////////////////////////////////////////////
  // pointer arithmetic
  //////////////////////////////////////////////////////////////////////

  // one extra bit so the compare sees the carry
  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_stp};
  assign wrap    = ptr_sum >= {1'b0, cfg_siz};
  // fraction carries across the wrap
  assign ptr_nxt = wrap ? PW'(ptr_sum - {1'b0, cfg_siz}) : ptr_sum[PW-1:0];
  assign rd_addr = ptr[PW-1:CWF];

  // burst counters
  assign dcnt_nxt   = dcnt + 1'b1;
  assign icnt_nxt   = icnt + 1'b1;
  assign ncnt_nxt   = ncnt + 1'b1;
  assign data_end   = dcnt_nxt >= cfg_bdl;
  assign burst_last = ~cfg_inf & (ncnt_nxt >= cfg_bnm);

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      ptr     <= '0;
      dcnt    <= '0;
      icnt    <= '0;
      ncnt    <= '0;
      rd_vld  <= 1'b0;
      trg_out <= 1'b0;
    end else if (ctl_rst) begin
      // software reset wins over everything
      state   <= IDLE;
      ptr     <= cfg_off;
      dcnt    <= '0;
      icnt    <= '0;
      ncnt    <= '0;
      rd_vld  <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      trg_out <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            ptr     <= cfg_off;
            dcnt    <= '0;
            ncnt    <= '0;
            rd_vld  <= 1'b1;
            trg_out <= 1'b1;
            state   <= cfg_ben ? BURST_DATA : RUN;
          end
        end
        RUN: begin
          // period marker on every wrap
          ptr     <= ptr_nxt;
          trg_out <= wrap;
        end
        BURST_DATA: begin
          ptr  <= ptr_nxt;
          dcnt <= dcnt_nxt;
          if (data_end) begin
            dcnt <= '0;
            ncnt <= ncnt_nxt;
            if (burst_last) begin
              state  <= DONE;
              rd_vld <= 1'b0;
            end else if (cfg_bil == '0) begin
              // back to back bursts
              ptr     <= cfg_off;
              trg_out <= 1'b1;
            end else begin
              state  <= BURST_IDLE;
              icnt   <= '0;
              rd_vld <= 1'b0;
            end
          end
        end
        BURST_IDLE: begin
          icnt <= icnt_nxt;
          if (icnt_nxt >= cfg_bil) begin
            state   <= BURST_DATA;
            ptr     <= cfg_off;
            rd_vld  <= 1'b1;
            trg_out <= 1'b1;
          end
        end
        // DONE waits for ctl_rst
        default: ;
      endcase
    end
  end

endmodule

// ==== asg_linear.sv ====
// gain and offset stage, out = sat(in * mul / 2**(DW-2) + sum)
// unity gain is 2**(DW-2), so gain tops out just under 2
// product is floored by the arithmetic shift
// one register stage for data and valid

`timescale 1ns/1ps

module asg_linear #(
  parameter int unsigned DW = 14
) (
  input  logic                 bus,
  input  logic                 arst_n,
  input  logic signed [DW-1:0] dat_in,
  input  logic                 vld_in,
  input  logic signed [DW-1:0] cfg_mul,
  input  logic signed [DW-1:0] cfg_sum,
  output logic signed [DW-1:0] dat,
  output logic                 dat_vld
);

  logic signed [2*DW-1:0] mul_full;
  logic signed [DW+2:0]   sum_full;
  logic                   in_range;
  logic signed [DW-1:0]   sat;

  // full product, scaled back to sample range plus growth bits
  assign mul_full = dat_in * cfg_mul;
  assign sum_full = (DW+3)'(mul_full >>> (DW - 2)) + (DW+3)'(cfg_sum);

  // fits when the bits above the sign all copy it
  assign in_range = (sum_full[DW+2:DW-1] == '0) || (sum_full[DW+2:DW-1] == '1);

  // clip to the signed limits
  always_comb begin
    if (in_range) begin
      sat = sum_full[DW-1:0];
    end else if (sum_full[DW+2]) begin
      sat = {1'b1, {(DW-1){1'b0}}};
    end else begin
      sat = {1'b0, {(DW-1){1'b1}}};
    end
  end

  always_ff @(posedge bus) begin
    dat <= sat;
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      dat_vld <= 1'b0;
    end else begin
      dat_vld <= vld_in;
    end
  end

endmodule

// ==== asg_pkg.sv ====
// shared widths, register map and core states for the generator
// register offsets are decoded on the low 6 address bits only,
// so the register block aliases every 64 bytes below the table window

package asg_pkg;

  // system bus
  localparam int unsigned BUS_DW = 32;
  localparam int unsigned BUS_AW = 16;

  typedef logic [BUS_DW-1:0] bus_data_t;
  typedef logic [BUS_AW-1:0] bus_addr_t;

  // address bit selecting the waveform table
  localparam int unsigned TBL_BIT = 15;

  // register offset decode width
  localparam int unsigned REG_AW = 6;

  // register offsets
  localparam logic [REG_AW-1:0] REG_CTL = 6'h00;
  localparam logic [REG_AW-1:0] REG_TRG = 6'h04;
  localparam logic [REG_AW-1:0] REG_SIZ = 6'h10;
  localparam logic [REG_AW-1:0] REG_OFF = 6'h14;
  localparam logic [REG_AW-1:0] REG_STP = 6'h18;
  localparam logic [REG_AW-1:0] REG_BST = 6'h20;
  localparam logic [REG_AW-1:0] REG_BDL = 6'h24;
  localparam logic [REG_AW-1:0] REG_BIL = 6'h28;
  localparam logic [REG_AW-1:0] REG_BNM = 6'h2c;
  localparam logic [REG_AW-1:0] REG_MUL = 6'h30;
  localparam logic [REG_AW-1:0] REG_SUM = 6'h34;

  // burst idle length and repetition count
  localparam int unsigned BIL_W = 32;
  localparam int unsigned BNM_W = 16;

  typedef logic [BIL_W-1:0] bil_t;
  typedef logic [BNM_W-1:0] bnm_t;

  // read pointer FSM
  typedef enum logic [2:0] {
    IDLE,
    RUN,
    BURST_DATA,
    BURST_IDLE,
    DONE
  } core_state_t;

endpackage

// ==== asg_regs.sv ====
// configuration registers of the generator
// every access answers one cycle later, no wait states
// REG_CTL bits are self clearing strobes and read back as zero
// all fields read back zero extended, gain and offset included

`timescale 1ns/1ps

module asg_regs import asg_pkg::*; #(
  parameter int unsigned CWM = 10,
  parameter int unsigned CWF = 16,
  parameter int unsigned TN  = 4,
  parameter int unsigned DW  = 14
) (
  input  logic               bus,
  input  logic               arst_n,
  input  logic               wen,
  input  logic               ren,
  input  bus_addr_t          addr,
  input  bus_data_t          wdata,
  output bus_data_t          rdata,
  output logic               ack,
  output logic               tbl_sel_q,
  output logic               ctl_rst,
  output logic               trg_swo,
  output logic [TN-1:0]      cfg_trg,
  output logic [CWM+CWF-1:0] cfg_siz,
  output logic [CWM+CWF-1:0] cfg_off,
  output logic [CWM+CWF-1:0] cfg_stp,
  output logic               cfg_ben,
  output logic               cfg_inf,
  output logic [CWM-1:0]     cfg_bdl,
  output bil_t               cfg_bil,
  output bnm_t               cfg_bnm,
  output logic [DW-1:0]      cfg_mul,
  output logic [DW-1:0]      cfg_sum
);

  // fixed point pointer width
  localparam int unsigned PW = CWM + CWF;

  logic              reg_wr;
  logic              reg_rd;
  logic [REG_AW-1:0] ofs;

  assign ofs    = addr[REG_AW-1:0];
  assign reg_wr = wen & ~addr[TBL_BIT];
  assign reg_rd = ren & ~addr[TBL_BIT];

  // control strobes, live only during the write cycle
  assign ctl_rst = reg_wr & (ofs == REG_CTL) & wdata[0];
  assign trg_swo = reg_wr & (ofs == REG_CTL) & wdata[1];

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ack       <= 1'b0;
      tbl_sel_q <= 1'b0;
    end else begin
      // table accesses are acknowledged by the buffer
      ack       <= reg_wr | reg_rd;
      // steers rdata in the top level during the ack cycle
      tbl_sel_q <= addr[TBL_BIT];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cfg_trg <= '0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_stp <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_bdl <= '0;
      cfg_bil <= '0;
      cfg_bnm <= '0;
      // unity gain
      cfg_mul <= DW'(1) << (DW - 2);
      cfg_sum <= '0;
    end else if (reg_wr) begin
      // each field masked to its own width
      case (ofs)
        REG_TRG: cfg_trg <= wdata[TN-1:0];
        REG_SIZ: cfg_siz <= wdata[PW-1:0];
        REG_OFF: cfg_off <= wdata[PW-1:0];
        REG_STP: cfg_stp <= wdata[PW-1:0];
        REG_BST: begin
          cfg_ben <= wdata[0];
          cfg_inf <= wdata[1];
        end
        REG_BDL: cfg_bdl <= wdata[CWM-1:0];
        REG_BIL: cfg_bil <= wdata[BIL_W-1:0];
        REG_BNM: cfg_bnm <= wdata[BNM_W-1:0];
        REG_MUL: cfg_mul <= wdata[DW-1:0];
        REG_SUM: cfg_sum <= wdata[DW-1:0];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reg_rd) begin
      case (ofs)
        REG_TRG: rdata <= bus_data_t'(cfg_trg);
        REG_SIZ: rdata <= bus_data_t'(cfg_siz);
        REG_OFF: rdata <= bus_data_t'(cfg_off);
        REG_STP: rdata <= bus_data_t'(cfg_stp);
        REG_BST: rdata <= bus_data_t'({cfg_inf, cfg_ben});
        REG_BDL: rdata <= bus_data_t'(cfg_bdl);
        REG_BIL: rdata <= bus_data_t'(cfg_bil);
        REG_BNM: rdata <= bus_data_t'(cfg_bnm);
        REG_MUL: rdata <= bus_data_t'(cfg_mul);
        REG_SUM: rdata <= bus_data_t'(cfg_sum);
        // REG_CTL and holes
        default: rdata <= '0;
      endcase
    end
  end

endmodule

// ==== asg_top.sv ====
// single channel arbitrary waveform generator
// table at address bit 15 set, registers below
// dat follows a pointer step by 2 cycles, no back-pressure

`timescale 1ns/1ps

module asg_top import asg_pkg::*; #(
  parameter int unsigned DW  = 14,
  parameter int unsigned CWM = 10,
  parameter int unsigned CWF = 16,
  parameter int unsigned TN  = 4
) (
  input  logic                 bus,
  input  logic                 arst_n,
  input  logic                 wen,
  input  logic                 ren,
  input  bus_addr_t            addr,
  input  bus_data_t            wdata,
  output bus_data_t            rdata,
  output logic                 ack,
  input  logic [TN-1:0]        trg_ext,
  output logic                 trg_swo,
  output logic                 trg_out,
  output logic signed [DW-1:0] dat,
  output logic                 dat_vld
);

  // bus side
  bus_data_t reg_rdata;
  bus_data_t buf_rdata;
  logic      reg_ack;
  logic      buf_ack;
  logic      tbl_sel_q;
  logic      ctl_rst;

  // configuration
  logic [TN-1:0]      cfg_trg;
  logic [CWM+CWF-1:0] cfg_siz;
  logic [CWM+CWF-1:0] cfg_off;
  logic [CWM+CWF-1:0] cfg_stp;
  logic               cfg_ben;
  logic               cfg_inf;
  logic [CWM-1:0]     cfg_bdl;
  bil_t               cfg_bil;
  bnm_t               cfg_bnm;
  logic [DW-1:0]      cfg_mul;
  logic [DW-1:0]      cfg_sum;

  // sample path
  logic [CWM-1:0] rd_addr;
  logic           rd_vld;
  logic [DW-1:0]  rd_dat;
  logic           buf_vld;

  // only one side answers any given access
  assign ack   = reg_ack | buf_ack;
  assign rdata = tbl_sel_q ? buf_rdata : reg_rdata;

  //////////////////////////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////////////////////////

  asg_regs #(.CWM(CWM), .CWF(CWF), .TN(TN), .DW(DW)) u_regs (
    .bus(bus), .arst_n(arst_n), .wen(wen), .ren(ren), .addr(addr), .wdata(wdata),
    .rdata(reg_rdata), .ack(reg_ack), .tbl_sel_q(tbl_sel_q),
    .ctl_rst(ctl_rst), .trg_swo(trg_swo),
    .cfg_trg(cfg_trg), .cfg_siz(cfg_siz), .cfg_off(cfg_off), .cfg_stp(cfg_stp),
    .cfg_ben(cfg_ben), .cfg_inf(cfg_inf), .cfg_bdl(cfg_bdl), .cfg_bil(cfg_bil),
    .cfg_bnm(cfg_bnm), .cfg_mul(cfg_mul), .cfg_sum(cfg_sum)
  );

  asg_buffer #(.CWM(CWM), .DW(DW)) u_buffer (
    .bus(bus), .arst_n(arst_n), .wen(wen), .ren(ren), .addr(addr), .wdata(wdata),
    .rdata(buf_rdata), .ack(buf_ack),
    .rd_addr(rd_addr), .rd_vld(rd_vld), .rd_dat(rd_dat), .dat_vld(buf_vld)
  );

  asg_core #(.CWM(CWM), .CWF(CWF), .TN(TN)) u_core (
    .bus(bus), .arst_n(arst_n), .trg_ext(trg_ext), .trg_swo(trg_swo),
    .ctl_rst(ctl_rst),
    .cfg_trg(cfg_trg), .cfg_siz(cfg_siz), .cfg_off(cfg_off), .cfg_stp(cfg_stp),
    .cfg_ben(cfg_ben), .cfg_inf(cfg_inf), .cfg_bdl(cfg_bdl), .cfg_bil(cfg_bil),
    .cfg_bnm(cfg_bnm),
    .rd_addr(rd_addr), .rd_vld(rd_vld), .trg_out(trg_out)
  );

  asg_linear #(.DW(DW)) u_linear (
    .bus(bus), .arst_n(arst_n), .dat_in(rd_dat), .vld_in(buf_vld),
    .cfg_mul(cfg_mul), .cfg_sum(cfg_sum), .dat(dat), .dat_vld(dat_vld)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_asg -Mdir obj_dir
out=$(./obj_dir/Vtb_asg)
echo "$out"
# pass only when the testbench printed its pass line
echo "$out" | grep -qx "NO ERRORS"

// ==== sim.f ====
asg_pkg.sv
asg_regs.sv
asg_buffer.sv
asg_core.sv
asg_linear.sv
asg_top.sv
tb_asg_assert.sv
tb_asg.sv

// ==== tb_asg.sv ====
// testbench for asg_top, configured over the bus, samples checked against a model
// table holds 32 random signed samples from a fixed seed, sizes stay within it
// inputs change on the falling edge, outputs are sampled there too
// every wait is bounded, errors are counted and reported at the end

`timescale 1ns/1ps

module tb_asg import asg_pkg::*; ();

  localparam int DW  = 14;
  localparam int CWM = 10;
  localparam int CWF = 16;
  localparam int TN  = 4;

  localparam int N_TBL   = 32;
  localparam int N_REG   = 12;
  localparam int N_TEST  = 7;
  localparam int BUS_TMO = 20;
  localparam int SMP_TMO = 2000;
  localparam int SRC_SW  = 0;
  localparam int SRC_EXT = 1;

  localparam bus_addr_t TBL_BASE = 16'h8000;

  // DUT ports
  logic                 bus;
  logic                 arst_n;
  logic                 wen;
  logic                 ren;
  bus_addr_t            addr;
  bus_data_t            wdata;
  bus_data_t            rdata;
  logic                 ack;
  logic [TN-1:0]        trg_ext;
  logic                 trg_swo;
  logic                 trg_out;
  logic signed [DW-1:0] dat;
  logic                 dat_vld;

  // table image and bookkeeping
  logic signed [DW-1:0] tbl [N_TBL];
  int                   seed;
  int                   val_err;
  int                   oth_err;
  int                   asr_err;
  int                   swo_cnt;
  int                   dat_q [$];
  bit                   mrk_q [$];
  int                   exp_dat [$];
  bit                   exp_mrk [$];
  logic                 trg_d1;
  logic                 trg_d2;

  // test table
  string t_name [N_TEST];
  int    t_ben  [N_TEST];
  int    t_siz  [N_TEST];
  int    t_stp  [N_TEST];
  int    t_off  [N_TEST];
  int    t_bdl  [N_TEST];
  int    t_bil  [N_TEST];
  int    t_bnm  [N_TEST];
  int    t_mul  [N_TEST];
  int    t_sum  [N_TEST];
  int    t_src  [N_TEST];
  int    t_n    [N_TEST];

  // register read-back table
  logic [REG_AW-1:0] r_ofs [N_REG];
  bit                r_wr  [N_REG];
  bus_data_t         r_dat [N_REG];
  bus_data_t         r_exp [N_REG];

  asg_top #(.DW(DW), .CWM(CWM), .CWF(CWF), .TN(TN)) UUT (
    .bus(bus), .arst_n(arst_n), .wen(wen), .ren(ren), .addr(addr), .wdata(wdata),
    .rdata(rdata), .ack(ack), .trg_ext(trg_ext), .trg_swo(trg_swo),
    .trg_out(trg_out), .dat(dat), .dat_vld(dat_vld)
  );

  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;
  end

  //////////////////////////////////////////////////////////////////////
  // sample collector
  //////////////////////////////////////////////////////////////////////

  // trg_out leads dat by the 2 cycle pipeline, delay it to line up
  always @(negedge bus) begin
    if (dat_vld) begin
      dat_q.push_back(int'(dat));
      mrk_q.push_back(trg_d2);
    end
    trg_d2 = trg_d1;
    trg_d1 = trg_out;
  end

  // cycles with the software trigger strobe high
  always @(posedge bus) begin
    if (trg_swo) begin
      swo_cnt++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus access
  //////////////////////////////////////////////////////////////////////

  task automatic bus_write(input bus_addr_t a, input bus_data_t d);
    int n;
    @(negedge bus);
    wen   = 1'b1;
    addr  = a;
    wdata = d;
    @(negedge bus);
    wen = 1'b0;
    n   = 0;
    while (!ack && n < BUS_TMO) begin
      @(negedge bus);
      n++;
    end
    if (!ack) begin
      oth_err++;
      $display("bus write to %h was never acknowledged", a);
    end
  endtask

  task automatic bus_read(input bus_addr_t a, output bus_data_t d);
    int n;
    @(negedge bus);
    ren  = 1'b1;
    addr = a;
    @(negedge bus);
    ren = 1'b0;
    n   = 0;
    while (!ack && n < BUS_TMO) begin
      @(negedge bus);
      n++;
    end
    d = rdata;
    if (!ack) begin
      oth_err++;
      $display("bus read from %h was never acknowledged", a);
    end
  endtask

  // one cycle high on the chosen trigger inputs
  task automatic pulse_ext(input logic [TN-1:0] m);
    @(negedge bus);
    trg_ext = m;
    @(negedge bus);
    trg_ext = '0;
  endtask

  // output must stay silent for the whole window
  task automatic quiet_window(input string what, input int cycles);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge bus);
      if (dat_vld) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      oth_err++;
      $display("%s: dat_vld went high when no output was expected", what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // floor of x * mul / 2**(DW-2), plus sum, clipped to the signed range
  function automatic int scale(input int x, input int mul, input int sum);
    int y;
    int hi;
    int lo;
    hi = (1 << (DW - 1)) - 1;
    lo = -(1 << (DW - 1));
    y  = (x * mul) >>> (DW - 2);
    y  = y + sum;
    if (y > hi) begin
      y = hi;
    end else if (y < lo) begin
      y = lo;
    end
    return y;
  endfunction

  function automatic int sample_at(input int ptr, input int t);
    return scale(int'(tbl[ptr >>> CWF]), t_mul[t], t_sum[t]);
  endfunction

  task automatic build_expected(input int t);
    int ptr;
    bit wrapped;
    exp_dat.delete();
    exp_mrk.delete();
    if (t_ben[t] == 0) begin
      // continuous, marker on start and on each wrap
      ptr     = t_off[t];
      wrapped = 1'b1;
      for (int k = 0; k < t_n[t]; k++) begin
        exp_dat.push_back(sample_at(ptr, t));
        exp_mrk.push_back(wrapped);
        ptr     = ptr + t_stp[t];
        wrapped = 1'b0;
        if (ptr >= t_siz[t]) begin
          ptr     = ptr - t_siz[t];
          wrapped = 1'b1;
        end
      end
    end else begin
      // bursts restart at the offset, marker on each first sample
      for (int b = 0; b < t_bnm[t]; b++) begin
        ptr = t_off[t];
        for (int d = 0; d < t_bdl[t]; d++) begin
          exp_dat.push_back(sample_at(ptr, t));
          exp_mrk.push_back(d == 0);
          ptr = ptr + t_stp[t];
          if (ptr >= t_siz[t]) begin
            ptr = ptr - t_siz[t];
          end
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tables
  //////////////////////////////////////////////////////////////////////

  task automatic set_test(input int i, input string nm, input int ben, input int siz,
                          input int stp, input int off, input int bdl, input int bil,
                          input int bnm, input int mul, input int sum, input int src,
                          input int n);
    t_name[i] = nm;
    t_ben[i]  = ben;
    t_siz[i]  = siz;
    t_stp[i]  = stp;
    t_off[i]  = off;
    t_bdl[i]  = bdl;
    t_bil[i]  = bil;
    t_bnm[i]  = bnm;
    t_mul[i]  = mul;
    t_sum[i]  = sum;
    t_src[i]  = src;
    t_n[i]    = n;
  endtask

  task automatic set_reg(input int i, input logic [REG_AW-1:0] ofs, input bit wr,
                         input bus_data_t d, input bus_data_t e);
    r_ofs[i] = ofs;
    r_wr[i]  = wr;
    r_dat[i] = d;
    r_exp[i] = e;
  endtask

  task automatic load_tables();
    // name, burst, size, step, offset, bdl, bil, bnm, gain, sum, source, samples
    set_test(0, "cont_step1", 0, 20 << 16, 1 << 16, 3 << 16, 0, 0, 0, 4096, 0, SRC_SW, 50);
    set_test(1, "cont_half", 0, 16 << 16, 32'h8000, 0, 0, 0, 0, 4096, 0, SRC_SW, 40);
    set_test(2, "cont_frac", 0, 13 << 16, 32'h14000, 32'h28000, 0, 0, 0, 4096, 0,
             SRC_SW, 60);
    set_test(3, "burst_fin", 1, 24 << 16, 1 << 16, 5 << 16, 7, 6, 3, 4096, 0, SRC_SW, 21);
    set_test(4, "burst_b2b", 1, 24 << 16, 32'h18000, 2 << 16, 5, 0, 4, 4096, 0,
             SRC_SW, 20);
    set_test(5, "gain_pos", 0, 32 << 16, 1 << 16, 0, 0, 0, 0, 6144, 4096, SRC_SW, 40);
    set_test(6, "gain_neg_ext", 0, 32 << 16, 1 << 16, 7 << 16, 0, 0, 0, -7000, -3000,
             SRC_EXT, 40);
    // reset values first, then writes with junk above each field
    set_reg(0, REG_MUL, 1'b0, 32'h0, 32'h0000_1000);
    set_reg(1, REG_CTL, 1'b0, 32'h0, 32'h0);
    set_reg(2, REG_TRG, 1'b1, 32'hffff_fffa, 32'h0000_000a);
    set_reg(3, REG_SIZ, 1'b1, 32'hffff_ffff, 32'h03ff_ffff);
    set_reg(4, REG_OFF, 1'b1, 32'h1234_5678, 32'h0234_5678);
    set_reg(5, REG_STP, 1'b1, 32'ha5a5_a5a5, 32'h01a5_a5a5);
    set_reg(6, REG_BST, 1'b1, 32'hffff_fffe, 32'h0000_0002);
    set_reg(7, REG_BDL, 1'b1, 32'h0000_fc37, 32'h0000_0037);
    set_reg(8, REG_BIL, 1'b1, 32'hdead_beef, 32'hdead_beef);
    set_reg(9, REG_BNM, 1'b1, 32'h1234_5678, 32'h0000_5678);
    set_reg(10, REG_SUM, 1'b1, 32'hffff_e001, 32'h0000_2001);
    set_reg(11, REG_MUL, 1'b1, 32'h0003_5555, 32'h0000_1555);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test steps
  //////////////////////////////////////////////////////////////////////

  task automatic check_regs();
    bus_data_t rd;
    for (int i = 0; i < N_REG; i++) begin
      if (r_wr[i]) begin
        bus_write(bus_addr_t'(r_ofs[i]), r_dat[i]);
      end
      bus_read(bus_addr_t'(r_ofs[i]), rd);
      if (rd !== r_exp[i]) begin
        val_err++;
        $display("ERR reg_%02h: expected %h, actual %h", r_ofs[i], r_exp[i], rd);
      end
    end
  endtask

  // upper bus bits carry random junk, only DW bits are kept
  task automatic fill_table();
    bus_data_t r;
    bus_data_t rd;
    bus_data_t ex;
    for (int i = 0; i < N_TBL; i++) begin
      r      = $random(seed);
      tbl[i] = r[DW-1:0];
      bus_write(TBL_BASE | bus_addr_t'(i << 2), r);
    end
    for (int i = 0; i < N_TBL; i++) begin
      bus_read(TBL_BASE | bus_addr_t'(i << 2), rd);
      ex = bus_data_t'(int'(tbl[i]));
      if (rd !== ex) begin
        val_err++;
        $display("ERR tbl_%0d: expected %h, actual %h", i, ex, rd);
      end
    end
  endtask

  task automatic run_test(input int t);
    int cnt;
    int swo0;
    int swo_exp;
    swo0 = swo_cnt;
    // park the core, then program every field
    bus_write(bus_addr_t'(REG_CTL), 32'h1);
    bus_write(bus_addr_t'(REG_TRG), (t_src[t] == SRC_EXT) ? 32'h4 : 32'h0);
    bus_write(bus_addr_t'(REG_SIZ), bus_data_t'(t_siz[t]));
    bus_write(bus_addr_t'(REG_OFF), bus_data_t'(t_off[t]));
    bus_write(bus_addr_t'(REG_STP), bus_data_t'(t_stp[t]));
    bus_write(bus_addr_t'(REG_BST), bus_data_t'(t_ben[t]));
    bus_write(bus_addr_t'(REG_BDL), bus_data_t'(t_bdl[t]));
    bus_write(bus_addr_t'(REG_BIL), bus_data_t'(t_bil[t]));
    bus_write(bus_addr_t'(REG_BNM), bus_data_t'(t_bnm[t]));
    bus_write(bus_addr_t'(REG_MUL), bus_data_t'(t_mul[t] & 32'h3fff));
    bus_write(bus_addr_t'(REG_SUM), bus_data_t'(t_sum[t] & 32'h3fff));
    build_expected(t);
    dat_q.delete();
    mrk_q.delete();
    if (t_src[t] == SRC_EXT) begin
      // input 0 is masked off and must start nothing
      pulse_ext(4'b0001);
      quiet_window({t_name[t], " masked trigger"}, 20);
      pulse_ext(4'b0100);
    end else begin
      bus_write(bus_addr_t'(REG_CTL), 32'h2);
    end
    cnt = 0;
    while (dat_q.size() < t_n[t] && cnt < SMP_TMO) begin
      @(negedge bus);
      cnt++;
    end
    if (dat_q.size() < t_n[t]) begin
      oth_err++;
      $display("%s: timed out with %0d of %0d samples", t_name[t], dat_q.size(), t_n[t]);
    end
    for (int k = 0; k < t_n[t] && k < dat_q.size(); k++) begin
      if (dat_q[k] != exp_dat[k]) begin
        val_err++;
        $display("ERR %s sample %0d: expected %0d, actual %0d", t_name[t], k,
                 exp_dat[k], dat_q[k]);
      end
      if (mrk_q[k] != exp_mrk[k]) begin
        val_err++;
        $display("ERR %s trg_out at sample %0d: expected %0d, actual %0d", t_name[t], k,
                 exp_mrk[k], mrk_q[k]);
      end
    end
    if (t_ben[t] != 0) begin
      // finished bursts stay finished
      quiet_window({t_name[t], " after last burst"}, 40);
      if (dat_q.size() != t_n[t]) begin
        val_err++;
        $display("ERR %s count: expected %0d, actual %0d", t_name[t], t_n[t], dat_q.size());
      end
    end
    // software reset, dat_vld drains within the pipeline depth
    bus_write(bus_addr_t'(REG_CTL), 32'h1);
    cnt = 0;
    while (dat_vld && cnt < 2) begin
      @(negedge bus);
      cnt++;
    end
    if (dat_vld) begin
      oth_err++;
      $display("%s: dat_vld still high 2 cycles after the reset write", t_name[t]);
    end
    quiet_window({t_name[t], " after reset"}, 10);
    // one strobe cycle per software trigger write, none for reset writes
    swo_exp = swo0 + ((t_src[t] == SRC_SW) ? 1 : 0);
    if (swo_cnt != swo_exp) begin
      val_err++;
      $display("ERR %s trg_swo cycles: expected %0d, actual %0d", t_name[t], swo_exp,
               swo_cnt);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed    = 32'ha80b_54b7;
    val_err = 0;
    oth_err = 0;
    swo_cnt = 0;
    trg_d1  = 1'b0;
    trg_d2  = 1'b0;
    arst_n  = 1'b0;
    wen     = 1'b0;
    ren     = 1'b0;
    addr    = '0;
    wdata   = '0;
    trg_ext = '0;
    load_tables();
    repeat (4) @(posedge bus);
    @(negedge bus);
    arst_n = 1'b1;
    check_regs();
    fill_table();
    for (int t = 0; t < N_TEST; t++) begin
      run_test(t);
    end
    // failures of the bound FSM assertions
    asr_err = UUT.u_core.u_assert.fail_cnt;
    if (asr_err != 0) begin
      oth_err += asr_err;
      $display("%0d assertion failures in the read pointer FSM", asr_err);
    end
    $display("closing count: %0d value errors, %0d other errors", val_err, oth_err);
    if (val_err + oth_err == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== tb_asg_assert.sv ====
// protocol assertions on the read pointer FSM, bound into asg_core
// the rd_addr range rule assumes an integer table size in cfg_siz

`timescale 1ns/1ps

module asg_assert import asg_pkg::*; #(
  parameter int unsigned CWM = 10,
  parameter int unsigned CWF = 16
) (
  input logic               bus,
  input logic               arst_n,
  input core_state_t        state,
  input logic               rd_vld,
  input logic [CWM-1:0]     rd_addr,
  input logic               trg_out,
  input logic [CWM+CWF-1:0] cfg_siz
);

  // failures per rule
  int n_trg = 0;
  int n_vld = 0;
  int n_addr = 0;
  int fail_cnt;

  assign fail_cnt = n_trg + n_vld + n_addr;

  // period and burst markers are single cycle
  a_trg_pulse: assert property (@(posedge bus) disable iff (!arst_n) trg_out |=> !trg_out)
    else begin
      n_trg++;
      $error("trg_out held high for two cycles");
    end

  // no reads while parked
  a_idle_vld: assert property (@(posedge bus) disable iff (!arst_n)
    (state == IDLE || state == DONE) |-> !rd_vld)
    else begin
      n_vld++;
      $error("rd_vld high in IDLE or DONE");
    end

  // pointer stays inside the table
  a_addr_range: assert property (@(posedge bus) disable iff (!arst_n)
    rd_vld |-> (rd_addr < cfg_siz[CWM+CWF-1:CWF]))
    else begin
      n_addr++;
      $error("rd_addr at or beyond the table size");
    end

endmodule

bind asg_core asg_assert #(.CWM(CWM), .CWF(CWF)) u_assert (
  .bus(bus), .arst_n(arst_n), .state(state), .rd_vld(rd_vld),
  .rd_addr(rd_addr), .trg_out(trg_out), .cfg_siz(cfg_siz)
);
